// ==== include/soc_ctrl_settings.svh ====
// ------------------------------------------------------------
// build settings for the SoC control register block
// include wherever bus widths, counts or reset values are needed
// ------------------------------------------------------------
`ifndef SOC_CTRL_SETTINGS_SVH
`define SOC_CTRL_SETTINGS_SVH

// bus
`define SOC_APB_ADDR_WIDTH 12

// identity register fields
`define SOC_NB_CORES 16'd4
`define SOC_NB_CLUSTERS 16'd0

// jtag mailbox width, each direction
`define SOC_JTAG_REG_SIZE 8

// pad control
`define SOC_N_PADS 64
`define SOC_PADS_PER_FUN_REG 16
`define SOC_PADS_PER_CFG_REG 4

// fabric controller boot address out of reset
`define SOC_FC_BOOT_RESET 32'h1A00_0080

`endif

// ==== src/soc_ctrl_pkg.sv ====
// ------------------------------------------------------------
// types shared by the SoC control register block
// ------------------------------------------------------------
`default_nettype none

`include "soc_ctrl_settings.svh"

package soc_ctrl_pkg;

   // word index taken from paddr[8:2]
   typedef enum logic [6:0] {
      REG_INFO               = 7'd0,
      REG_FCBOOT             = 7'd1,
      REG_FCFETCH            = 7'd2,
      REG_PADFUN0            = 7'd4,
      REG_PADFUN1            = 7'd5,
      REG_PADFUN2            = 7'd6,
      REG_PADFUN3            = 7'd7,
      REG_PADCFG0            = 7'd8,
      REG_PADCFG1            = 7'd9,
      REG_PADCFG2            = 7'd10,
      REG_PADCFG3            = 7'd11,
      REG_PADCFG4            = 7'd12,
      REG_PADCFG5            = 7'd13,
      REG_PADCFG6            = 7'd14,
      REG_PADCFG7            = 7'd15,
      REG_PADCFG8            = 7'd16,
      REG_PADCFG9            = 7'd17,
      REG_PADCFG10           = 7'd18,
      REG_PADCFG11           = 7'd19,
      REG_PADCFG12           = 7'd20,
      REG_PADCFG13           = 7'd21,
      REG_PADCFG14           = 7'd22,
      REG_PADCFG15           = 7'd23,
      REG_CLUSTER_CTRL       = 7'd28,
      REG_JTAGREG            = 7'd29,
      REG_CLUSTER_IRQ        = 7'd31,
      REG_CLUSTER_BOOT_ADDR0 = 7'd32,
      REG_CLUSTER_BOOT_ADDR1 = 7'd33,
      REG_CORESTATUS         = 7'd40,
      REG_CS_RO              = 7'd48,
      REG_BOOTSEL            = 7'd49,
      REG_CLKSEL             = 7'd50
   } reg_idx_e;

   typedef struct packed {
      logic                           psel;
      logic                           penable;
      logic                           pwrite;
      logic [`SOC_APB_ADDR_WIDTH-1:0] paddr;
      logic [31:0]                    pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic        valid; // one-cycle write strobe
      reg_idx_e    idx;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef struct packed {
      logic [1:0] drive;      // drive strength
      logic       slew_limit;
      logic       schmitt;
      logic       pull_down;
      logic       pull_up;    // bit 0
   } pad_cfg_t;

   typedef struct packed {
      logic rstn;     // active low cluster reset
      logic fetch_en;
      logic pow;
      logic byp;      // bit 0
   } cluster_ctrl_t;

endpackage

`default_nettype wire

// ==== src/apb_reg_decode.sv ====
// ------------------------------------------------------------
// APB front end: write strobe and word index for the register
// blocks, read data merge, zero-wait response
// ------------------------------------------------------------
`default_nettype none

module apb_reg_decode
   import soc_ctrl_pkg::*;
(
   input  apb_req_t    apb_req_i,
   output apb_rsp_t    apb_rsp_o,
   output reg_wr_t     reg_wr_o,
   output reg_idx_e    rd_idx_o,
   input  logic [31:0] pad_rd_data_i,
   input  logic [31:0] fc_rd_data_i,
   input  logic [31:0] cl_rd_data_i
);

   logic [6:0] word_idx; // paddr[8:2]
   logic       apb_write;

   assign word_idx  = apb_req_i.paddr[8:2];
   assign apb_write = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

   // write path, registers update at the edge closing the access phase
   always_comb
   begin
      reg_wr_o.valid = apb_write;
      reg_wr_o.idx   = reg_idx_e'(word_idx);
      reg_wr_o.wdata = apb_req_i.pwdata;
   end

   assign rd_idx_o = reg_idx_e'(word_idx);

   // each block returns zero outside its own map so a plain OR is enough
   always_comb
   begin
      apb_rsp_o.prdata  = pad_rd_data_i | fc_rd_data_i | cl_rd_data_i;
      apb_rsp_o.pready  = 1'b1; // no wait states
      apb_rsp_o.pslverr = 1'b0;
   end

endmodule

`default_nettype wire

// ==== src/pad_ctrl_regs.sv ====
// ------------------------------------------------------------
// pad mux select and pad configuration registers
// written and read through the PADFUN and PADCFG words
// ------------------------------------------------------------
`default_nettype none

`include "soc_ctrl_settings.svh"

module pad_ctrl_regs
   import soc_ctrl_pkg::*;
(
   input  logic                             HCLK,
   input  logic                             HRESETn,
   input  reg_wr_t                          reg_wr_i,
   input  reg_idx_e                         rd_idx_i,
   output logic [31:0]                      rd_data_o,
   output logic [`SOC_N_PADS-1:0][1:0]      pad_mux_o,
   output pad_cfg_t [`SOC_N_PADS-1:0]       pad_cfg_o
);

   localparam int PADS_PER_FUN = `SOC_PADS_PER_FUN_REG;
   localparam int PADS_PER_CFG = `SOC_PADS_PER_CFG_REG;
   localparam int N_FUN_REGS   = `SOC_N_PADS / PADS_PER_FUN;
   localparam int N_CFG_REGS   = `SOC_N_PADS / PADS_PER_CFG;
   localparam int CFG_BITS     = $bits(pad_cfg_t);

   logic [`SOC_N_PADS-1:0][1:0] r_pad_mux;
   pad_cfg_t [`SOC_N_PADS-1:0]  r_pad_cfg;

   assign pad_mux_o = r_pad_mux;
   assign pad_cfg_o = r_pad_cfg;

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_pad_mux <= '0;
         r_pad_cfg <= '1; // every pad config field set
      end
      else if (reg_wr_i.valid)
      begin
         // sixteen 2-bit selects per word
         for (int r = 0; r < N_FUN_REGS; r++)
         begin
            if (reg_wr_i.idx == reg_idx_e'(REG_PADFUN0 + r))
            begin
               for (int i = 0; i < PADS_PER_FUN; i++)
                  r_pad_mux[r*PADS_PER_FUN+i] <= reg_wr_i.wdata[2*i +: 2];
            end
         end
         // one byte per pad, top two bits dropped
         for (int r = 0; r < N_CFG_REGS; r++)
         begin
            if (reg_wr_i.idx == reg_idx_e'(REG_PADCFG0 + r))
            begin
               for (int i = 0; i < PADS_PER_CFG; i++)
                  r_pad_cfg[r*PADS_PER_CFG+i] <= pad_cfg_t'(reg_wr_i.wdata[8*i +: CFG_BITS]);
            end
         end
      end
   end

   // read back with the same packing, unused bits zero
   always_comb
   begin
      rd_data_o = '0;
      for (int r = 0; r < N_FUN_REGS; r++)
      begin
         if (rd_idx_i == reg_idx_e'(REG_PADFUN0 + r))
         begin
            for (int i = 0; i < PADS_PER_FUN; i++)
               rd_data_o[2*i +: 2] = r_pad_mux[r*PADS_PER_FUN+i];
         end
      end
      for (int r = 0; r < N_CFG_REGS; r++)
      begin
         if (rd_idx_i == reg_idx_e'(REG_PADCFG0 + r))
         begin
            for (int i = 0; i < PADS_PER_CFG; i++)
               rd_data_o[8*i +: CFG_BITS] = r_pad_cfg[r*PADS_PER_CFG+i];
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/fc_boot_status_regs.sv ====
// ------------------------------------------------------------
// fabric controller boot and status registers, identity word,
// jtag mailbox and synchronized boot/clock select inputs
// ------------------------------------------------------------
`default_nettype none

`include "soc_ctrl_settings.svh"

module fc_boot_status_regs
   import soc_ctrl_pkg::*;
(
   input  logic                          HCLK,
   input  logic                          HRESETn,
   input  reg_wr_t                       reg_wr_i,
   input  reg_idx_e                      rd_idx_i,
   output logic [31:0]                   rd_data_o,
   input  logic                          sel_fll_clk_i,
   input  logic                          bootsel_i,
   input  logic                          fc_fetch_en_valid_i,
   input  logic                          fc_fetch_en_i,
   input  logic [`SOC_JTAG_REG_SIZE-1:0] soc_jtag_reg_i,
   output logic [`SOC_JTAG_REG_SIZE-1:0] soc_jtag_reg_o,
   output logic [31:0]                   fc_bootaddr_o,
   output logic                          fc_fetchen_o
);

   localparam int JW = `SOC_JTAG_REG_SIZE;

   logic [31:0]        r_bootaddr;
   logic               r_fetchen;
   logic [31:0]        r_corestatus; // EOC in bit 31, status below
   logic [JW-1:0]      r_jtag_out;
   logic [1:0][JW-1:0] r_jtag_sync;  // [1] is the settled value
   logic [1:0]         r_bootsel;

   assign fc_bootaddr_o  = r_bootaddr;
   assign fc_fetchen_o   = r_fetchen;
   assign soc_jtag_reg_o = r_jtag_out;

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_bootaddr   <= `SOC_FC_BOOT_RESET;
         r_fetchen    <= 1'b0;
         r_corestatus <= '0;
         r_jtag_out   <= '0;
         r_jtag_sync  <= '0;
         r_bootsel    <= '0;
      end
      else
      begin
         r_jtag_sync[0] <= soc_jtag_reg_i;
         r_jtag_sync[1] <= r_jtag_sync[0];
         r_bootsel      <= {r_bootsel[0], bootsel_i};

         if (fc_fetch_en_valid_i)
            r_fetchen <= fc_fetch_en_i; // external request, bus write below overrides

         if (reg_wr_i.valid)
         begin
            case (reg_wr_i.idx)
               REG_FCBOOT:     r_bootaddr   <= reg_wr_i.wdata;
               REG_FCFETCH:    r_fetchen    <= reg_wr_i.wdata[0];
               REG_CORESTATUS: r_corestatus <= reg_wr_i.wdata;
               REG_JTAGREG:    r_jtag_out   <= reg_wr_i.wdata[JW-1:0];
               default:        ;
            endcase
         end
      end
   end

   always_comb
   begin
      rd_data_o = '0;
      case (rd_idx_i)
         REG_INFO:       rd_data_o = {`SOC_NB_CORES, `SOC_NB_CLUSTERS};
         REG_FCBOOT:     rd_data_o = r_bootaddr;
         REG_FCFETCH:    rd_data_o[0] = r_fetchen;
         REG_CORESTATUS: rd_data_o = r_corestatus;
         REG_CS_RO:      rd_data_o = r_corestatus; // read-only mirror
         REG_BOOTSEL:    rd_data_o[1:0] = r_bootsel;
         REG_CLKSEL:     rd_data_o[0] = sel_fll_clk_i;
         REG_JTAGREG:
         begin
            rd_data_o[2*JW-1:JW] = r_jtag_sync[1];
            rd_data_o[JW-1:0]    = r_jtag_out;
         end
         default:        rd_data_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/cluster_ctrl_regs.sv ====
// ------------------------------------------------------------
// cluster control bits, cluster interrupt and 64-bit cluster
// boot address, written over APB
// ------------------------------------------------------------
`default_nettype none

module cluster_ctrl_regs
   import soc_ctrl_pkg::*;
(
   input  logic          HCLK,
   input  logic          HRESETn,
   input  reg_wr_t       reg_wr_i,
   input  reg_idx_e      rd_idx_i,
   output logic [31:0]   rd_data_o,
   output cluster_ctrl_t cluster_ctrl_o,
   output logic          cluster_irq_o,
   output logic [63:0]   cluster_boot_addr_o
);

   localparam int CTRL_BITS = $bits(cluster_ctrl_t);

   cluster_ctrl_t r_ctrl;
   logic          r_irq;
   logic [63:0]   r_boot_addr;

   assign cluster_ctrl_o      = r_ctrl;
   assign cluster_irq_o       = r_irq;
   assign cluster_boot_addr_o = r_boot_addr;

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         // cluster out of reset but bypassed and unpowered
         r_ctrl.rstn     <= 1'b1;
         r_ctrl.fetch_en <= 1'b0;
         r_ctrl.pow      <= 1'b0;
         r_ctrl.byp      <= 1'b1;
         r_irq           <= 1'b0;
         r_boot_addr     <= '0;
      end
      else if (reg_wr_i.valid)
      begin
         case (reg_wr_i.idx)
            REG_CLUSTER_CTRL:       r_ctrl <= cluster_ctrl_t'(reg_wr_i.wdata[CTRL_BITS-1:0]);
            REG_CLUSTER_IRQ:        r_irq  <= reg_wr_i.wdata[0];
            REG_CLUSTER_BOOT_ADDR0: r_boot_addr[31:0]  <= reg_wr_i.wdata; // low word
            REG_CLUSTER_BOOT_ADDR1: r_boot_addr[63:32] <= reg_wr_i.wdata;
            default:                ;
         endcase
      end
   end

   always_comb
   begin
      rd_data_o = '0;
      case (rd_idx_i)
         REG_CLUSTER_CTRL:       rd_data_o[CTRL_BITS-1:0] = r_ctrl;
         REG_CLUSTER_IRQ:        rd_data_o[0] = r_irq;
         REG_CLUSTER_BOOT_ADDR0: rd_data_o = r_boot_addr[31:0];
         REG_CLUSTER_BOOT_ADDR1: rd_data_o = r_boot_addr[63:32];
         default:                rd_data_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/apb_soc_ctrl.sv ====
// ------------------------------------------------------------
// SoC control APB slave, top level
// decoder plus pad, boot/status and cluster register blocks
// ------------------------------------------------------------
`default_nettype none

`include "soc_ctrl_settings.svh"

module apb_soc_ctrl
   import soc_ctrl_pkg::*;
(
   input  logic                             HCLK,
   input  logic                             HRESETn,
   input  apb_req_t                         apb_req_i,
   output apb_rsp_t                         apb_rsp_o,

   output logic [`SOC_N_PADS-1:0][1:0]      pad_mux_o,
   output pad_cfg_t [`SOC_N_PADS-1:0]       pad_cfg_o,

   input  logic                             sel_fll_clk_i,
   input  logic                             bootsel_i,
   input  logic                             fc_fetch_en_valid_i,
   input  logic                             fc_fetch_en_i,
   input  logic [`SOC_JTAG_REG_SIZE-1:0]    soc_jtag_reg_i,
   output logic [`SOC_JTAG_REG_SIZE-1:0]    soc_jtag_reg_o,
   output logic [31:0]                      fc_bootaddr_o,
   output logic                             fc_fetchen_o,

   output cluster_ctrl_t                    cluster_ctrl_o,
   output logic                             cluster_irq_o,
   output logic [63:0]                      cluster_boot_addr_o
);

   reg_wr_t     reg_wr;       // shared write strobe
   reg_idx_e    rd_idx;
   logic [31:0] pad_rd_data;
   logic [31:0] fc_rd_data;
   logic [31:0] cl_rd_data;

   apb_reg_decode u_decode (
      .apb_req_i     (apb_req_i),
      .apb_rsp_o     (apb_rsp_o),
      .reg_wr_o      (reg_wr),
      .rd_idx_o      (rd_idx),
      .pad_rd_data_i (pad_rd_data),
      .fc_rd_data_i  (fc_rd_data),
      .cl_rd_data_i  (cl_rd_data)
   );

   pad_ctrl_regs u_pad (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .reg_wr_i  (reg_wr),
      .rd_idx_i  (rd_idx),
      .rd_data_o (pad_rd_data),
      .pad_mux_o (pad_mux_o),
      .pad_cfg_o (pad_cfg_o)
   );

   fc_boot_status_regs u_fc (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .reg_wr_i            (reg_wr),
      .rd_idx_i            (rd_idx),
      .rd_data_o           (fc_rd_data),
      .sel_fll_clk_i       (sel_fll_clk_i),
      .bootsel_i           (bootsel_i),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .soc_jtag_reg_i      (soc_jtag_reg_i),
      .soc_jtag_reg_o      (soc_jtag_reg_o),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o)
   );

   cluster_ctrl_regs u_cluster (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .reg_wr_i            (reg_wr),
      .rd_idx_i            (rd_idx),
      .rd_data_o           (cl_rd_data),
      .cluster_ctrl_o      (cluster_ctrl_o),
      .cluster_irq_o       (cluster_irq_o),
      .cluster_boot_addr_o (cluster_boot_addr_o)
   );

endmodule

`default_nettype wire

// ==== sim/tb_apb_soc_ctrl.sv ====
// ------------------------------------------------------------
// table-driven testbench for the SoC control APB slave
// runs each register group through writes, reads and output checks
// ------------------------------------------------------------
`default_nettype none

`include "soc_ctrl_settings.svh"

module tb_apb_soc_ctrl
   import soc_ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   typedef enum {OP_WR, OP_RD, OP_WAIT} op_e;

   typedef struct {
      op_e         op;
      logic [6:0]  idx;
      logic [31:0] data; // write data or cycle count for OP_WAIT
      logic [31:0] exp;
   } entry_t;

   logic                          HCLK;
   logic                          HRESETn;
   apb_req_t                      apb_req;
   apb_rsp_t                      apb_rsp;
   logic [`SOC_N_PADS-1:0][1:0]   pad_mux;
   pad_cfg_t [`SOC_N_PADS-1:0]    pad_cfg;
   logic                          sel_fll_clk;
   logic                          bootsel;
   logic                          fetch_en_valid;
   logic                          fetch_en;
   logic [`SOC_JTAG_REG_SIZE-1:0] jtag_in;
   logic [`SOC_JTAG_REG_SIZE-1:0] jtag_out;
   logic [31:0]                   fc_bootaddr;
   logic                          fc_fetchen;
   cluster_ctrl_t                 cluster_ctrl;
   logic                          cluster_irq;
   logic [63:0]                   cluster_boot_addr;

   entry_t      table_q[$];
   integer      seed = 32'h1776;
   int          errors = 0;
   int          test_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   logic [31:0] fun_w[4];
   logic [31:0] cfg_w[16];
   logic [31:0] boot, cs, ctrl, ba_lo, ba_hi, jout;
   logic [7:0]  jin;

   apb_soc_ctrl u_dut (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .apb_req_i           (apb_req),
      .apb_rsp_o           (apb_rsp),
      .pad_mux_o           (pad_mux),
      .pad_cfg_o           (pad_cfg),
      .sel_fll_clk_i       (sel_fll_clk),
      .bootsel_i           (bootsel),
      .fc_fetch_en_valid_i (fetch_en_valid),
      .fc_fetch_en_i       (fetch_en),
      .soc_jtag_reg_i      (jtag_in),
      .soc_jtag_reg_o      (jtag_out),
      .fc_bootaddr_o       (fc_bootaddr),
      .fc_fetchen_o        (fc_fetchen),
      .cluster_ctrl_o      (cluster_ctrl),
      .cluster_irq_o       (cluster_irq),
      .cluster_boot_addr_o (cluster_boot_addr)
   );

   always #20 HCLK = ~HCLK; // 40 ns period

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp)
      begin
         $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, act);
         errors++;
      end
   endtask

   // setup then access until pready with read data sampled mid-cycle
   task automatic apb_access(input logic wr, input logic [6:0] idx, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      int n;
      @(posedge HCLK);
      #5;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = `SOC_APB_ADDR_WIDTH'({idx, 2'b00});
      apb_req.pwdata  = wdata;
      @(posedge HCLK);
      #5;
      apb_req.penable = 1'b1;
      @(negedge HCLK);
      n = 0;
      while (!apb_rsp.pready && n < 16)
      begin
         @(negedge HCLK);
         n++;
      end
      if (!apb_rsp.pready)
      begin
         $display("timeout: pready stayed low on access to index %0d", idx);
         errors++;
      end
      rdata = apb_rsp.prdata;
      compare("pslverr", 64'd0, 64'(apb_rsp.pslverr));
      @(posedge HCLK); // access ends here
      #5;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
   endtask

   task automatic add(input op_e op, input logic [6:0] idx, input logic [31:0] data,
                      input logic [31:0] exp);
      entry_t e;
      e.op   = op;
      e.idx  = idx;
      e.data = data;
      e.exp  = exp;
      table_q.push_back(e);
   endtask

   task automatic run_table();
      logic [31:0] rdata;
      int          n;
      foreach (table_q[k])
      begin
         case (table_q[k].op)
            OP_WR: apb_access(1'b1, table_q[k].idx, table_q[k].data, rdata);
            OP_RD:
            begin
               apb_access(1'b0, table_q[k].idx, 32'h0, rdata);
               compare($sformatf("prdata[idx %0d]", table_q[k].idx), 64'(table_q[k].exp),
                       64'(rdata));
            end
            default:
            begin
               n = 0;
               while (n < table_q[k].data && n < 1000) // bounded wait
               begin
                  @(posedge HCLK);
                  n++;
               end
               #5;
            end
         endcase
      end
      table_q.delete();
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != test_errors)
         tests_failed++;
      $display("test %0d %s: %s (%0d errors)", tests_run, name,
               (errors == test_errors) ? "PASS" : "FAIL", errors - test_errors);
      test_errors = errors;
   endtask

   initial
   begin
      HCLK = 1'b0;
      HRESETn = 1'b0;
      apb_req = '0;
      sel_fll_clk = 1'b0;
      bootsel = 1'b0;
      fetch_en_valid = 1'b0;
      fetch_en = 1'b0;
      jtag_in = '0;
      repeat (2) @(posedge HCLK);
      #5 HRESETn = 1'b1;

      // reset state
      add(OP_RD, REG_INFO, 0, 32'h0004_0000);
      add(OP_RD, REG_FCBOOT, 0, 32'h1A00_0080);
      add(OP_RD, REG_CLUSTER_CTRL, 0, 32'h9);
      add(OP_RD, REG_PADCFG5, 0, 32'h3F3F_3F3F);
      add(OP_RD, REG_PADFUN0, 0, 32'h0);
      run_table();
      compare("fc_fetchen_o", 0, 64'(fc_fetchen));
      compare("cluster_ctrl_o.rstn", 1, 64'(cluster_ctrl.rstn));
      compare("cluster_ctrl_o.byp", 1, 64'(cluster_ctrl.byp));
      for (int p = 0; p < `SOC_N_PADS; p++)
      begin
         compare($sformatf("pad_mux_o[%0d]", p), 0, 64'(pad_mux[p]));
         compare($sformatf("pad_cfg_o[%0d]", p), 64'h3F, 64'(pad_cfg[p]));
      end
      end_test("reset state");

      // random words into every PADFUN and PADCFG register
      for (int r = 0; r < 4; r++)
         fun_w[r] = $random(seed);
      for (int r = 0; r < 16; r++)
         cfg_w[r] = $random(seed);
      for (int r = 0; r < 4; r++)
         add(OP_WR, 7'(REG_PADFUN0 + r), fun_w[r], 0);
      for (int r = 0; r < 16; r++)
         add(OP_WR, 7'(REG_PADCFG0 + r), cfg_w[r], 0);
      for (int r = 0; r < 4; r++)
         add(OP_RD, 7'(REG_PADFUN0 + r), 0, fun_w[r]);
      for (int r = 0; r < 16; r++)
         add(OP_RD, 7'(REG_PADCFG0 + r), 0, cfg_w[r] & 32'h3F3F_3F3F);
      run_table();
      for (int p = 0; p < `SOC_N_PADS; p++)
      begin
         compare($sformatf("pad_mux_o[%0d]", p), 64'(fun_w[p/16][2*(p%16) +: 2]),
                 64'(pad_mux[p]));
         compare($sformatf("pad_cfg_o[%0d]", p), 64'(cfg_w[p/4][8*(p%4) +: 6]),
                 64'(pad_cfg[p]));
      end
      end_test("pad registers");

      // boot address, fetch enable, core status
      boot = $random(seed);
      cs   = $random(seed);
      add(OP_WR, REG_FCBOOT, boot, 0);
      add(OP_WR, REG_FCFETCH, 32'h1, 0);
      run_table();
      compare("fc_bootaddr_o", 64'(boot), 64'(fc_bootaddr));
      compare("fc_fetchen_o", 1, 64'(fc_fetchen));
      @(posedge HCLK);
      #5;
      fetch_en_valid = 1'b1; // external request clears fetch
      fetch_en = 1'b0;
      @(posedge HCLK);
      #5;
      fetch_en_valid = 1'b0;
      compare("fc_fetchen_o", 0, 64'(fc_fetchen));
      add(OP_WR, REG_CORESTATUS, cs, 0);
      add(OP_RD, REG_CORESTATUS, 0, cs);
      add(OP_RD, REG_CS_RO, 0, cs);
      add(OP_WR, REG_CS_RO, ~cs, 0); // mirror ignores writes
      add(OP_RD, REG_CORESTATUS, 0, cs);
      add(OP_RD, REG_CS_RO, 0, cs);
      add(OP_RD, REG_FCFETCH, 0, 32'h0);
      run_table();
      end_test("boot and fetch");

      // cluster control
      ctrl  = $random(seed);
      ba_lo = $random(seed);
      ba_hi = $random(seed);
      add(OP_WR, REG_CLUSTER_CTRL, ctrl, 0);
      add(OP_WR, REG_CLUSTER_IRQ, 32'h1, 0);
      add(OP_WR, REG_CLUSTER_BOOT_ADDR0, ba_lo, 0);
      add(OP_WR, REG_CLUSTER_BOOT_ADDR1, ba_hi, 0);
      add(OP_RD, REG_CLUSTER_CTRL, 0, ctrl & 32'hF);
      add(OP_RD, REG_CLUSTER_IRQ, 0, 32'h1);
      add(OP_RD, REG_CLUSTER_BOOT_ADDR0, 0, ba_lo);
      add(OP_RD, REG_CLUSTER_BOOT_ADDR1, 0, ba_hi);
      run_table();
      compare("cluster_ctrl_o", 64'(ctrl[3:0]), 64'(cluster_ctrl));
      compare("cluster_irq_o", 1, 64'(cluster_irq));
      compare("cluster_boot_addr_o", {ba_hi, ba_lo}, cluster_boot_addr);
      end_test("cluster control");

      // jtag mailbox and synchronized selects
      jout = $random(seed);
      jin  = $random(seed);
      add(OP_WR, REG_JTAGREG, jout, 0);
      run_table();
      // the read below samples exactly two edges after this drive
      jtag_in = jin;
      fork
         begin
            @(posedge HCLK);
            #5;
            jtag_in = ~jin; // must not reach the read yet
         end
      join_none
      add(OP_RD, REG_JTAGREG, 0, {16'h0, jin, jout[7:0]});
      run_table();
      bootsel = 1'b1;
      fork
         begin
            @(posedge HCLK);
            #5;
            bootsel = 1'b0; // one-cycle pulse
         end
      join_none
      add(OP_RD, REG_BOOTSEL, 0, 32'h2); // pulse moved from bit 0 to bit 1
      run_table();
      bootsel = 1'b1;
      sel_fll_clk = 1'b1;
      add(OP_WAIT, 0, 2, 0);
      add(OP_RD, REG_JTAGREG, 0, {16'h0, ~jin, jout[7:0]});
      add(OP_RD, REG_BOOTSEL, 0, 32'h3);
      add(OP_RD, REG_CLKSEL, 0, 32'h1);
      run_table();
      compare("soc_jtag_reg_o", 64'(jout[7:0]), 64'(jtag_out));
      end_test("synchronized inputs");

      // unmapped words read zero and leave every register alone
      add(OP_RD, 7'd3, 0, 32'h0);
      add(OP_RD, 7'd60, 0, 32'h0);
      add(OP_WR, 7'd3, 32'hFFFF_FFFF, 0);
      add(OP_WR, 7'd60, 32'hFFFF_FFFF, 0);
      add(OP_RD, 7'd3, 0, 32'h0);
      add(OP_RD, 7'd60, 0, 32'h0);
      add(OP_RD, REG_FCBOOT, 0, boot);
      add(OP_RD, REG_FCFETCH, 0, 32'h0);
      add(OP_RD, REG_CORESTATUS, 0, cs);
      add(OP_RD, REG_CLUSTER_CTRL, 0, ctrl & 32'hF);
      add(OP_RD, REG_CLUSTER_BOOT_ADDR0, 0, ba_lo);
      add(OP_RD, REG_CLUSTER_BOOT_ADDR1, 0, ba_hi);
      add(OP_RD, REG_JTAGREG, 0, {16'h0, ~jin, jout[7:0]});
      for (int r = 0; r < 4; r++)
         add(OP_RD, 7'(REG_PADFUN0 + r), 0, fun_w[r]);
      for (int r = 0; r < 16; r++)
         add(OP_RD, 7'(REG_PADCFG0 + r), 0, cfg_w[r] & 32'h3F3F_3F3F);
      run_table();
      compare("fc_bootaddr_o", 64'(boot), 64'(fc_bootaddr));
      compare("cluster_boot_addr_o", {ba_hi, ba_lo}, cluster_boot_addr);
      compare("cluster_irq_o", 1, 64'(cluster_irq));
      end_test("unmapped addresses");

      $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
src/soc_ctrl_pkg.sv
src/apb_reg_decode.sv
src/pad_ctrl_regs.sv
src/fc_boot_status_regs.sv
src/cluster_ctrl_regs.sv
src/apb_soc_ctrl.sv
sim/tb_apb_soc_ctrl.sv
